// ==== Makefile ====
# Verilator build and run of the alignment buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_align_buffer
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard logic/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/align_buffer_top.sv ====
// Instruction alignment buffer between the word prefetcher and the decode stage
`timescale 1ns/100ps
`default_nettype none

module align_buffer_top #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // Controller
  input  logic                  branch_i,
  input  logic [ADDR_WIDTH-1:0] branch_addr_i,

  // Prefetcher requests
  output logic                  fetch_valid_o,
  input  logic                  fetch_ready_i,
  output logic                  fetch_branch_o,
  output logic [ADDR_WIDTH-1:0] fetch_branch_addr_o,

  // Prefetcher responses
  input  logic                  resp_valid_i,
  input  fetch_pkg::word_t      resp_rdata_i,
  input  logic                  resp_err_i,

  // Decode stage
  output logic                  instr_valid_o,
  input  logic                  instr_ready_i,
  output fetch_pkg::word_t      instr_rdata_o,
  output logic                  instr_err_o,
  output logic [ADDR_WIDTH-1:0] instr_addr_o,

  output logic                  busy_o
);

  import fetch_pkg::*;
  import rvc_pkg::*;

  logic       resp_accept;
  logic       emit;
  logic       word_done;
  instr_cnt_t avail_cnt;

  // Buffer head and the word behind it
  logic       head_valid;
  word_t      head_word;
  logic       head_err;
  logic       next_valid;
  word_t      next_word;
  logic       next_err;

  fetch_request_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_request_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .branch_i            (branch_i),
    .branch_addr_i       (branch_addr_i),
    .fetch_ready_i       (fetch_ready_i),
    .resp_valid_i        (resp_valid_i),
    .avail_cnt_i         (avail_cnt),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .busy_o              (busy_o),
    .resp_accept_o       (resp_accept)
  );

  word_buffer u_word_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .resp_accept_i (resp_accept),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .word_done_i   (word_done),
    .head_valid_o  (head_valid),
    .head_word_o   (head_word),
    .head_err_o    (head_err),
    .next_valid_o  (next_valid),
    .next_word_o   (next_word),
    .next_err_o    (next_err)
  );

  // Only bit 1 of the target matters for parcel counting
  instr_counter u_instr_counter (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_half_i (branch_addr_i[1]),
    .resp_accept_i (resp_accept),
    .resp_rdata_i  (resp_rdata_i),
    .emit_i        (emit),
    .avail_cnt_o   (avail_cnt)
  );

  instr_aligner #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .resp_accept_i (resp_accept),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .head_valid_i  (head_valid),
    .head_word_i   (head_word),
    .head_err_i    (head_err),
    .next_valid_i  (next_valid),
    .next_word_i   (next_word),
    .next_err_i    (next_err),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .instr_addr_o  (instr_addr_o),
    .emit_o        (emit),
    .word_done_o   (word_done)
  );

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
// Fetch word, buffer index and in-flight request types shared by the alignment buffer
`default_nettype none

package fetch_pkg;

  // One bus word as returned by the prefetcher
  typedef logic [31:0] word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Word buffer sizing
  ////////////////////////////////////////////////////////////////////////////

  // Three words cover a split 32-bit instruction plus one word in flight
  localparam int BUF_DEPTH = 3;
  typedef logic [1:0] buf_ptr_t;

  // Prefetcher request limit
  localparam int MAX_OUTSTANDING = 2;
  typedef logic [1:0] outstanding_t;

  // Step a buffer index with wrap after the last entry
  function automatic buf_ptr_t ptr_step(buf_ptr_t ptr);
    buf_ptr_t nxt;
    if (ptr == buf_ptr_t'(BUF_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + buf_ptr_t'(1);
    end
    return nxt;
  endfunction

endpackage

`default_nettype wire

// ==== logic/fetch_request_ctrl.sv ====
// Prefetch request control with in-flight tracking and flush of stale responses after a branch
`timescale 1ns/100ps
`default_nettype none

module fetch_request_ctrl #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  branch_i,
  input  logic [ADDR_WIDTH-1:0] branch_addr_i,
  input  logic                  fetch_ready_i,
  input  logic                  resp_valid_i,
  input  rvc_pkg::instr_cnt_t   avail_cnt_i,
  output logic                  fetch_valid_o,
  output logic                  fetch_branch_o,
  output logic [ADDR_WIDTH-1:0] fetch_branch_addr_o,
  output logic                  busy_o,
  output logic                  resp_accept_o
);

  import fetch_pkg::*;
  import rvc_pkg::*;

  outstanding_t outstanding_q;
  outstanding_t outstanding_d;
  outstanding_t flush_q;
  outstanding_t flush_d;
  logic         active_q;
  logic         req_accepted;
  logic         want_word;

  ////////////////////////////////////////////////////////////////////////////
  // Request decision
  ////////////////////////////////////////////////////////////////////////////

  // Ask for more only when the buffer is about to run dry
  assign want_word = branch_i ||
                     (avail_cnt_i == '0) ||
                     ((avail_cnt_i == instr_cnt_t'(1)) && (outstanding_q == '0));

  // No fetching before the first branch gives a start address
  assign fetch_valid_o = (active_q || branch_i) &&
                         (outstanding_q < outstanding_t'(MAX_OUTSTANDING)) &&
                         want_word;

  assign req_accepted = fetch_valid_o && fetch_ready_i;

  // Branch goes straight to the prefetcher, halfword aligned
  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = {branch_addr_i[ADDR_WIDTH-1:1], 1'b0};

  assign busy_o = (outstanding_q != '0) || fetch_valid_o;

  // Stale responses never reach the buffer
  assign resp_accept_o = resp_valid_i && (flush_q == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    outstanding_d = outstanding_q;
    if (req_accepted && !resp_valid_i) begin
      outstanding_d = outstanding_q + outstanding_t'(1);
    end else if (!req_accepted && resp_valid_i) begin
      outstanding_d = outstanding_q - outstanding_t'(1);
    end
  end

  always_comb begin
    flush_d = flush_q;
    if (branch_i) begin
      // Everything in flight is old, less a response landing right now
      flush_d = outstanding_q - outstanding_t'(resp_valid_i);
    end else if (resp_valid_i && (flush_q != '0)) begin
      flush_d = flush_q - outstanding_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      flush_q       <= '0;
      active_q      <= 1'b0;
    end else begin
      outstanding_q <= outstanding_d;
      flush_q       <= flush_d;
      if (branch_i) begin
        active_q <= 1'b1;
      end
    end
  end

  // Prefetcher limit holds
  a_outstanding_limit : assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= outstanding_t'(MAX_OUTSTANDING))
    else $error("more than %0d fetch requests in flight", MAX_OUTSTANDING);

  // Responses to flush always belong to requests still in flight
  a_flush_bound : assert property (@(posedge clk) disable iff (!rst_n)
    flush_q <= outstanding_q)
    else $error("flush count above in-flight count");

endmodule

`default_nettype wire

// ==== logic/instr_aligner.sv ====
// Output instruction assembly from buffered and incoming parcels with address tracking
`timescale 1ns/100ps
`default_nettype none

module instr_aligner #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  branch_i,
  input  logic [ADDR_WIDTH-1:0] branch_addr_i,
  input  logic                  resp_accept_i,
  input  fetch_pkg::word_t      resp_rdata_i,
  input  logic                  resp_err_i,
  input  logic                  head_valid_i,
  input  fetch_pkg::word_t      head_word_i,
  input  logic                  head_err_i,
  input  logic                  next_valid_i,
  input  fetch_pkg::word_t      next_word_i,
  input  logic                  next_err_i,
  input  logic                  instr_ready_i,
  output logic                  instr_valid_o,
  output fetch_pkg::word_t      instr_rdata_o,
  output logic                  instr_err_o,
  output logic [ADDR_WIDTH-1:0] instr_addr_o,
  output logic                  emit_o,
  output logic                  word_done_o
);

  import fetch_pkg::*;
  import rvc_pkg::*;

  logic [ADDR_WIDTH-1:0] addr_q;
  logic [ADDR_WIDTH-1:0] addr_step;
  word_t                 cur_word;
  logic                  cur_err;
  word_t                 sec_word;
  logic                  sec_err;
  half_t                 first_parcel;
  half_t                 second_parcel;
  logic                  unaligned;
  logic                  compressed;
  logic                  avail;
  logic                  pair_avail;

  ////////////////////////////////////////////////////////////////////////////
  // Parcel selection
  ////////////////////////////////////////////////////////////////////////////

  // Head word, or the bus word when the buffer is empty
  assign cur_word = head_valid_i ? head_word_i : resp_rdata_i;
  assign cur_err  = head_valid_i ? head_err_i  : resp_err_i;

  // Word after the head, from the buffer or the bus
  assign sec_word = next_valid_i ? next_word_i : resp_rdata_i;
  assign sec_err  = next_valid_i ? next_err_i  : resp_err_i;

  assign unaligned     = addr_q[1];
  assign first_parcel  = unaligned ? cur_word[31:16] : cur_word[15:0];
  assign second_parcel = unaligned ? sec_word[15:0]  : cur_word[31:16];
  assign compressed    = !is_full(first_parcel);

  // Some word holds the first parcel
  assign avail = head_valid_i || resp_accept_i;

  // Both words present for a 32-bit instruction across the boundary
  assign pair_avail = next_valid_i || (head_valid_i && resp_accept_i);

  // Branch cycle never emits
  assign instr_valid_o = !branch_i && avail && (!unaligned || compressed || pair_avail);

  // Compressed zero-extended, so stray upper bits never reach decode
  assign instr_rdata_o = compressed ? {16'h0000, first_parcel} : {second_parcel, first_parcel};

  // Error of every word the instruction touches
  assign instr_err_o = cur_err || (unaligned && !compressed && sec_err);

  assign instr_addr_o = addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and address
  ////////////////////////////////////////////////////////////////////////////

  assign emit_o = instr_valid_o && instr_ready_i;

  // Head is used up by an upper parcel or a full aligned word
  assign word_done_o = emit_o && (unaligned || !compressed);

  assign addr_step = compressed ? ADDR_WIDTH'(2) : ADDR_WIDTH'(4);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      addr_q <= {branch_addr_i[ADDR_WIDTH-1:1], 1'b0};
    end else if (emit_o) begin
      addr_q <= addr_q + addr_step;
    end
  end

  // Stalled instruction stays put unless a branch cuts in
  a_hold_stalled : assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && !instr_ready_i && !branch_i |=>
      branch_i || (instr_valid_o && $stable(instr_rdata_o) && $stable(instr_addr_o)))
    else $error("instruction changed under decode back-pressure");

endmodule

`default_nettype wire

// ==== logic/instr_counter.sv ====
// Whole instruction count from arriving words by tracking parcel alignment
`timescale 1ns/100ps
`default_nettype none

module instr_counter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                branch_i,
  input  logic                branch_half_i,
  input  logic                resp_accept_i,
  input  fetch_pkg::word_t    resp_rdata_i,
  input  logic                emit_i,
  output rvc_pkg::instr_cnt_t avail_cnt_o
);

  import rvc_pkg::*;

  // Parse state at the next word boundary
  // aligned   next word starts with an instruction
  // complete  set with !aligned only after a branch to an upper parcel
  logic          aligned_q;
  logic          aligned_d;
  logic          complete_q;
  logic          complete_d;
  logic          lo_done;
  half_t         lo_parcel;
  half_t         hi_parcel;
  incoming_cnt_t incoming;
  instr_cnt_t    cnt_q;
  instr_cnt_t    cnt_d;
  logic          pop_q;

  assign lo_parcel = resp_rdata_i[15:0];
  assign hi_parcel = resp_rdata_i[31:16];

  // Lower parcel closes an instruction when compressed and aligned
  // or when it carries the tail of a split instruction
  assign lo_done = aligned_q || !complete_q;

  ////////////////////////////////////////////////////////////////////////////
  // Parcel parsing
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    aligned_d  = aligned_q;
    complete_d = complete_q;
    incoming   = '0;
    if (branch_i) begin
      // Target halfword sets the parse position
      aligned_d  = !branch_half_i;
      complete_d = branch_half_i;
    end else if (resp_accept_i) begin
      if (aligned_q && is_full(lo_parcel)) begin
        // One 32-bit instruction fills the word, state unchanged
        incoming = incoming_cnt_t'(1);
      end else if (is_full(hi_parcel)) begin
        // Upper parcel opens an instruction split into the next word
        incoming   = incoming_cnt_t'(lo_done);
        aligned_d  = 1'b0;
        complete_d = 1'b0;
      end else begin
        // Compressed upper parcel ends the word cleanly
        incoming   = incoming_cnt_t'(lo_done) + incoming_cnt_t'(1);
        aligned_d  = 1'b1;
        complete_d = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction count
  ////////////////////////////////////////////////////////////////////////////

  // Emits subtracted a cycle late to keep decode ready off the count path
  always_comb begin
    if (branch_i) begin
      cnt_d = '0;
    end else begin
      cnt_d = cnt_q + instr_cnt_t'(incoming) - instr_cnt_t'(pop_q);
    end
  end

  assign avail_cnt_o = cnt_q - instr_cnt_t'(pop_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aligned_q  <= 1'b1;
      complete_q <= 1'b1;
      cnt_q      <= '0;
      pop_q      <= 1'b0;
    end else begin
      aligned_q  <= aligned_d;
      complete_q <= complete_d;
      cnt_q      <= cnt_d;
      pop_q      <= emit_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rvc_pkg.sv ====
// Compressed instruction encoding and instruction count types for the RISC-V fetch path
`default_nettype none

package rvc_pkg;

  // One 16-bit instruction parcel
  typedef logic [15:0] half_t;

  // Low opcode bits of a parcel that starts a 32-bit instruction
  localparam logic [1:0] FULL_QUADRANT = 2'b11;

  // Whole instructions held in the buffer, up to two per word
  typedef logic [2:0] instr_cnt_t;

  // Instructions completed by a single arriving word
  typedef logic [1:0] incoming_cnt_t;

  // Parcel opens a 32-bit instruction
  function automatic logic is_full(half_t parcel);
    return parcel[1:0] == FULL_QUADRANT;
  endfunction

endpackage

`default_nettype wire

// ==== logic/word_buffer.sv ====
// Three-entry circular store of fetched words with head and next read ports
`timescale 1ns/100ps
`default_nettype none

module word_buffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             branch_i,
  input  logic             resp_accept_i,
  input  fetch_pkg::word_t resp_rdata_i,
  input  logic             resp_err_i,
  input  logic             word_done_i,
  output logic             head_valid_o,
  output fetch_pkg::word_t head_word_o,
  output logic             head_err_o,
  output logic             next_valid_o,
  output fetch_pkg::word_t next_word_o,
  output logic             next_err_o
);

  import fetch_pkg::*;

  word_t                data_q [BUF_DEPTH];
  logic [BUF_DEPTH-1:0] err_q;
  logic [BUF_DEPTH-1:0] valid_q;
  logic [BUF_DEPTH-1:0] valid_d;
  buf_ptr_t             wptr_q;
  buf_ptr_t             rptr_q;
  buf_ptr_t             nptr;

  // Entry behind the head
  assign nptr = ptr_step(rptr_q);

  assign head_valid_o = valid_q[rptr_q];
  assign head_word_o  = data_q[rptr_q];
  assign head_err_o   = err_q[rptr_q];
  assign next_valid_o = valid_q[nptr];
  assign next_word_o  = data_q[nptr];
  assign next_err_o   = err_q[nptr];

  always_comb begin
    valid_d = valid_q;
    if (resp_accept_i) begin
      valid_d[wptr_q] = 1'b1;
    end
    // Retire after the write
    // A word used straight from the bus is written and dropped together
    if (word_done_i) begin
      valid_d[rptr_q] = 1'b0;
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    if (resp_accept_i) begin
      data_q[wptr_q] <= resp_rdata_i;
      err_q[wptr_q]  <= resp_err_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else if (branch_i) begin
      // Whole buffer dropped in one cycle
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= valid_d;
      if (resp_accept_i) begin
        wptr_q <= ptr_step(wptr_q);
      end
      if (word_done_i) begin
        rptr_q <= nptr;
      end
    end
  end

  // Request throttling keeps the buffer from overflowing
  a_no_overwrite : assert property (@(posedge clk) disable iff (!rst_n)
    resp_accept_i && !branch_i |-> !valid_q[wptr_q])
    else $error("response written over a valid buffer entry");

  // Aligner only retires words that exist
  a_retire_valid : assert property (@(posedge clk) disable iff (!rst_n)
    word_done_i |-> valid_q[rptr_q] || resp_accept_i)
    else $error("head retired with no word present");

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+testbench
logic/fetch_pkg.sv
logic/rvc_pkg.sv
logic/fetch_request_ctrl.sv
logic/word_buffer.sv
logic/instr_counter.sv
logic/instr_aligner.sv
logic/align_buffer_top.sv
testbench/tb_align_buffer.sv

// ==== testbench/tb_fetch_model.svh ====
// Instruction memory, word prefetcher and reference decoder models for the alignment buffer test
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

localparam int    MEM_WORDS   = 256;
localparam int    LAT_MAX     = 4;
localparam addr_t TARGET_BASE = 32'h0000_2000;

// Memory image, one error flag per word
word_t mem_word [MEM_WORDS];
logic  mem_err  [MEM_WORDS];

// Prefetcher state, owned by the monitor process
int    cycle_cnt;
addr_t pf_next;
addr_t pend_addr [$];
int    pend_due  [$];

// Response for the coming cycle
logic  nr_valid;
word_t nr_data;
logic  nr_err;

// Memory wraps every MEM_WORDS words
function automatic int word_index(addr_t addr);
  return int'(addr[9:2]);
endfunction

function automatic half_t mem_half(addr_t addr);
  word_t w;
  w = mem_word[word_index(addr)];
  return addr[1] ? w[31:16] : w[15:0];
endfunction

// About half the parcels open a 32-bit instruction
function automatic half_t random_parcel();
  half_t p;
  p = half_t'($urandom);
  if (($urandom % 2) == 0) begin
    p[1:0] = FULL_QUADRANT;
  end else if (p[1:0] == FULL_QUADRANT) begin
    p[1:0] = 2'b01;
  end
  return p;
endfunction

task automatic fill_memory();
  half_t lo;
  half_t hi;
  for (int i = 0; i < MEM_WORDS; i++) begin
    lo          = random_parcel();
    hi          = random_parcel();
    mem_word[i] = {hi, lo};
    mem_err[i]  = ($urandom % 8) == 0;
  end
endtask

// Halfword target, bit 0 left random since the buffer clears it
function automatic addr_t pick_target(logic unal);
  addr_t t;
  t = TARGET_BASE + addr_t'(($urandom % (MEM_WORDS * 2)) * 2);
  if (unal) begin
    t[1] = 1'b1;
  end
  t[0] = ($urandom % 2) != 0;
  return t;
endfunction

// Expected instruction at addr with its length in bytes
task automatic decode_at(input addr_t addr, output word_t data, output logic err,
                         output int len);
  half_t first;
  first = mem_half(addr);
  if (first[1:0] != FULL_QUADRANT) begin
    data = {16'h0000, first};
    err  = mem_err[word_index(addr)];
    len  = 2;
  end else begin
    // Second parcel may sit in the following word
    data = {mem_half(addr + addr_t'(2)), first};
    err  = mem_err[word_index(addr)] || mem_err[word_index(addr + addr_t'(2))];
    len  = 4;
  end
endtask

// Record an accepted request, restarting at the branch word
task automatic prefetch_sample();
  addr_t base;
  base = fetch_branch_o ? {fetch_branch_addr_o[ADDR_WIDTH-1:2], 2'b00} : pf_next;
  if (fetch_valid_o && fetch_ready_i) begin
    pend_addr.push_back(base);
    pend_due.push_back(cycle_cnt + 1 + int'($urandom % LAT_MAX));
    pf_next = base + addr_t'(4);
  end else begin
    pf_next = base;
  end
endtask

// In order, at most one per cycle, garbage on the bus when idle
task automatic schedule_response();
  addr_t a;
  nr_valid = 1'b0;
  nr_data  = $urandom;
  nr_err   = ($urandom % 2) != 0;
  if (pend_due.size() > 0) begin
    if (pend_due[0] <= cycle_cnt + 1) begin
      a = pend_addr.pop_front();
      void'(pend_due.pop_front());
      nr_valid = 1'b1;
      nr_data  = mem_word[word_index(a)];
      nr_err   = mem_err[word_index(a)];
    end
  end
endtask

`endif

// ==== testbench/tb_align_buffer.sv ====
// Testbench for the alignment buffer with random fetch traffic against a reference decoder
`timescale 1ns/100ps
`default_nettype none

module tb_align_buffer;

  import fetch_pkg::*;
  import rvc_pkg::*;

  localparam int ADDR_WIDTH = 32;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  logic  clk;
  logic  rst_n;
  logic  branch_i;
  addr_t branch_addr_i;
  logic  fetch_valid_o;
  logic  fetch_ready_i;
  logic  fetch_branch_o;
  addr_t fetch_branch_addr_o;
  logic  resp_valid_i;
  word_t resp_rdata_i;
  logic  resp_err_i;
  logic  instr_valid_o;
  logic  instr_ready_i;
  word_t instr_rdata_o;
  logic  instr_err_o;
  addr_t instr_addr_o;
  logic  busy_o;

  // Stimulus knobs set by the main sequence
  int   fetch_pct;
  int   instr_pct;
  int   branch_pct;
  logic unaligned_only;
  int   start_seq;
  int   start_done;
  logic drive_on;
  logic timed_out;

  // Monitor state
  int    checks;
  int    errors;
  int    emit_cnt;
  int    inflight;
  logic  seen_branch;
  addr_t exp_addr;
  logic  stall_prev;
  word_t stall_data;
  addr_t stall_addr;

  `include "tb_fetch_model.svh"

  align_buffer_top #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) uut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .branch_i            (branch_i),
    .branch_addr_i       (branch_addr_i),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .resp_valid_i        (resp_valid_i),
    .resp_rdata_i        (resp_rdata_i),
    .resp_err_i          (resp_err_i),
    .instr_valid_o       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .instr_rdata_o       (instr_rdata_o),
    .instr_err_o         (instr_err_o),
    .instr_addr_o        (instr_addr_o),
    .busy_o              (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor sampling mid-cycle when every signal has settled
  ////////////////////////////////////////////////////////////////////////////

  task automatic observe_cycle();
    word_t exp_data;
    logic  exp_err;
    int    len;
    // Nothing moves until the first branch gives a start address
    if (!seen_branch && !branch_i) begin
      check_flag("fetch_valid_o before first branch", fetch_valid_o, 1'b0);
      check_flag("instr_valid_o before first branch", instr_valid_o, 1'b0);
      check_flag("busy_o before first branch", busy_o, 1'b0);
    end
    // Busy while anything is in flight or a request is offered
    check_flag("busy_o", busy_o, (inflight != 0) || fetch_valid_o);
    prefetch_sample();
    if (fetch_valid_o && fetch_ready_i) begin
      inflight++;
    end
    if (resp_valid_i) begin
      inflight--;
    end
    check_flag("requests in flight within limit", inflight <= MAX_OUTSTANDING, 1'b1);
    // Stalled instruction must be offered again unchanged
    if (stall_prev && !branch_i) begin
      check_flag("instr_valid_o under stall", instr_valid_o, 1'b1);
      check_word("instr_rdata_o under stall", instr_rdata_o, stall_data);
      check_addr("instr_addr_o under stall", instr_addr_o, stall_addr);
    end
    stall_prev = 1'b0;
    if (branch_i) begin
      // Target with bit 0 cleared
      exp_addr = branch_addr_i & ~addr_t'(1);
      check_flag("instr_valid_o in branch cycle", instr_valid_o, 1'b0);
      check_flag("fetch_branch_o", fetch_branch_o, 1'b1);
      check_addr("fetch_branch_addr_o", fetch_branch_addr_o, exp_addr);
      seen_branch = 1'b1;
    end else if (instr_valid_o && instr_ready_i) begin
      decode_at(exp_addr, exp_data, exp_err, len);
      check_addr("instr_addr_o", instr_addr_o, exp_addr);
      // Only the lower parcel of a compressed instruction counts
      if (len == 2) begin
        check_word("instr_rdata_o", {16'h0000, instr_rdata_o[15:0]}, exp_data);
      end else begin
        check_word("instr_rdata_o", instr_rdata_o, exp_data);
      end
      check_flag("instr_err_o", instr_err_o, exp_err);
      exp_addr = exp_addr + addr_t'(len);
      emit_cnt++;
    end else if (instr_valid_o) begin
      stall_prev = 1'b1;
      stall_data = instr_rdata_o;
      stall_addr = instr_addr_o;
    end
  endtask

  initial begin
    checks      = 0;
    errors      = 0;
    emit_cnt    = 0;
    inflight    = 0;
    seen_branch = 1'b0;
    exp_addr    = '0;
    stall_prev  = 1'b0;
    stall_data  = '0;
    stall_addr  = '0;
    cycle_cnt   = 0;
    pf_next     = '0;
    nr_valid    = 1'b0;
    nr_data     = '0;
    nr_err      = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        cycle_cnt++;
        observe_cycle();
        schedule_response();
      end
    end
  end

  // Input driver 2 ns after the rising edge
  initial begin
    branch_i      = 1'b0;
    branch_addr_i = '0;
    fetch_ready_i = 1'b0;
    resp_valid_i  = 1'b0;
    resp_rdata_i  = '0;
    resp_err_i    = 1'b0;
    instr_ready_i = 1'b0;
    start_done    = 0;
    forever begin
      @(posedge clk);
      #2;
      if (drive_on) begin
        resp_valid_i  = nr_valid;
        resp_rdata_i  = nr_data;
        resp_err_i    = nr_err;
        fetch_ready_i = ($urandom % 100) < fetch_pct;
        instr_ready_i = ($urandom % 100) < instr_pct;
        branch_i      = 1'b0;
        // Start branch of a test, or a random one
        if (start_done != start_seq || ($urandom % 100) < branch_pct) begin
          branch_i      = 1'b1;
          branch_addr_i = pick_target(unaligned_only);
          start_done    = start_seq;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_emits(input int count, input int limit, output logic ok);
    int target;
    int cycles;
    target = emit_cnt + count;
    cycles = 0;
    while (emit_cnt < target && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    ok = emit_cnt >= target;
  endtask

  task automatic check_idle(input int cycles);
    int err_start;
    err_start = errors;
    repeat (cycles) @(posedge clk);
    $display("test reset_idle: %0d quiet cycles, %0d errors", cycles, errors - err_start);
  endtask

  task automatic run_test(input string name, input int b_pct, input logic unal,
                          input int f_pct, input int i_pct, input int count);
    int   err_start;
    logic ok;
    if (!timed_out) begin
      err_start      = errors;
      fetch_pct      = f_pct;
      instr_pct      = i_pct;
      branch_pct     = b_pct;
      unaligned_only = unal;
      start_seq++;
      wait_emits(count, 40 * count + 200, ok);
      if (!ok) begin
        timed_out = 1'b1;
        $display("timeout: test %s stopped delivering instructions", name);
      end
      $display("test %s: %0d instructions, %0d errors", name, count, errors - err_start);
    end
  endtask

  initial begin
    void'($urandom(32'h9ec0));
    rst_n          = 1'b0;
    drive_on       = 1'b0;
    timed_out      = 1'b0;
    fetch_pct      = 0;
    instr_pct      = 0;
    branch_pct     = 0;
    unaligned_only = 1'b0;
    start_seq      = 0;
    fill_memory();
    repeat (8) @(posedge clk);
    #2;
    rst_n    = 1'b1;
    drive_on = 1'b1;
    check_idle(30);
    run_test("straight_line", 0, 1'b0, 70, 70, 400);
    run_test("random_branches", 3, 1'b0, 70, 70, 600);
    run_test("unaligned_branches", 3, 1'b1, 70, 70, 400);
    run_test("decode_stall", 1, 1'b0, 50, 20, 200);
    run_test("full_speed", 0, 1'b0, 100, 100, 300);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
